//--- ad9434_capture.f
+incdir+hdl
hdl/adc_pkg.sv
hdl/s2mm_pkg.sv
hdl/capture_ctrl.sv
hdl/sample_packer.sv
hdl/beat_fifo.sv
hdl/s2mm_writer.sv
hdl/ad9434_capture.sv
bench/ad9434_capture_assert.sv
bench/capture_checker.sv
bench/tb_ad9434_capture.sv

//--- bench/ad9434_capture_assert.sv
module ad9434_capture_assert
  import s2mm_pkg::*;
(
  input logic  adc_clk,
  input logic  rst,
  input logic  o_cap_done,
  input logic  o_fifo_overflow,
  input logic  o_s2mm_cmd_tvalid,
  input cmd_t  o_s2mm_cmd_tdata,
  input logic  i_s2mm_cmd_tready,
  input logic  o_s2mm_wr_tvalid,
  input beat_t o_s2mm_wr_tdata,
  input logic  i_s2mm_wr_tready
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // read by the testbench for the closing line

  cmd_hold: assert property (@(posedge adc_clk) disable iff (rst)
    o_s2mm_cmd_tvalid && !i_s2mm_cmd_tready |=>
      o_s2mm_cmd_tvalid && $stable(o_s2mm_cmd_tdata))
    else begin
      $error("command tvalid dropped or tdata changed before tready");
      fail_cnt++;
    end

  data_hold: assert property (@(posedge adc_clk) disable iff (rst)
    o_s2mm_wr_tvalid && !i_s2mm_wr_tready |=>
      o_s2mm_wr_tvalid && $stable(o_s2mm_wr_tdata))
    else begin
      $error("data tvalid dropped or tdata changed before tready");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge adc_clk) disable iff (rst)
    o_cap_done |=> !o_cap_done)
    else begin
      $error("o_cap_done held longer than one cycle");
      fail_cnt++;
    end

  no_overflow: assert property (@(posedge adc_clk) disable iff (rst)
    !o_fifo_overflow)
    else begin
      $error("beat fifo overflowed");
      fail_cnt++;
    end

endmodule

//--- bench/capture_checker.sv
`include "ad9434_cfg.svh"

module capture_checker
  import adc_pkg::*;
  import s2mm_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_trig,
  input  us_count_t i_us_capture,
  input  half_t     i_q1,
  input  half_t     i_q2,
  input  logic      i_cap_done,
  input  logic      i_cmd_tvalid,
  input  logic      i_cmd_tready,
  input  cmd_t      i_cmd_tdata,
  input  logic      i_wr_tvalid,
  input  logic      i_wr_tready,
  input  beat_t     i_wr_tdata,
  input  keep_t     i_wr_tkeep,
  input  logic      i_wr_tlast,
  input  logic      i_sts_tvalid,
  input  logic      i_sts_tlast,
  input  sts_t      i_sts_tdata,
  output int        o_err_cnt,
  output int        o_blocks,
  output int        o_samples
);
  timeunit 1ns;
  timeprecision 100ps;

  // tag a, base 0400_0000, drr 0, type byte 01 at bit 23, 256 bytes in the low 9 bits
  localparam cmd_t EXP_CMD = 72'h0A_0400_0000_0080_0100;

  sample_t smp_q[$];           // captured samples not yet seen in a beat
  longint  cyc;                // edges since reset release
  longint  win_start;          // first sampling edge of the window
  longint  win_end;            // last sampling edge
  longint  done_at;            // edge where o_cap_done must be seen
  bit      prev_trig;
  bit      block_open;         // command taken, block not yet closed
  bit      wait_sts;           // tlast taken, status pending
  int      beat_idx;

  initial begin
    o_err_cnt = 0;
    o_blocks  = 0;
    o_samples = 0;
  end

  task automatic report_value(input string name, input logic [71:0] exp_v,
                              input logic [71:0] got_v);
    $display("Error at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
    o_err_cnt++;
  endtask

  task automatic report_fault(input string msg);
    $display("Error at %0t: %s", $time, msg);
    o_err_cnt++;
  endtask

  always @(posedge i_clk) begin
    beat_t exp_beat;
    logic  exp_last;
    if (i_rst) begin
      cyc        = 0;
      prev_trig  = 1'b0;
      done_at    = -1;
      win_start  = 1;
      win_end    = 0;
      block_open = 1'b0;
      wait_sts   = 1'b0;
      beat_idx   = 0;
    end else begin
      cyc++;
      // edge seen here, run begins two edges later, first sample one after that
      if (i_trig && !prev_trig && cyc + 2 > done_at) begin
        win_start = cyc + 3;
        win_end   = cyc + 2 + longint'(i_us_capture) * `ADC_CYCLES_PER_US;
        done_at   = win_end + 1;
      end
      prev_trig = i_trig;
      if (cyc >= win_start && cyc <= win_end) begin
        smp_q.push_back({i_q1, i_q2});
        o_samples++;
      end
      if (i_cap_done !== (cyc == done_at))
        report_value("o_cap_done", 72'(cyc == done_at), 72'(i_cap_done));

      if (i_cmd_tvalid && i_cmd_tready) begin
        if (block_open) report_fault("command issued before status closed the previous block");
        if (i_cmd_tdata !== EXP_CMD) report_value("o_s2mm_cmd_tdata", EXP_CMD, i_cmd_tdata);
        block_open = 1'b1;
        wait_sts   = 1'b0;
        beat_idx   = 0;
      end

      if (i_wr_tvalid && i_wr_tready) begin
        if (!block_open || wait_sts) report_fault("data beat outside a commanded block");
        if (smp_q.size() < 4) begin
          report_fault("data beat sent before four samples were captured");
        end else begin
          for (int l = 0; l < 4; l++) exp_beat[16*l +: 16] = lane_t'(smp_q.pop_front());
          if (i_wr_tdata !== exp_beat) report_value("o_s2mm_wr_tdata", exp_beat, i_wr_tdata);
        end
        exp_last = (beat_idx == `BLOCK_BEATS - 1);
        if (i_wr_tlast !== exp_last) report_value("o_s2mm_wr_tlast", exp_last, i_wr_tlast);
        if (i_wr_tkeep !== 8'hff) report_value("o_s2mm_wr_tkeep", 8'hff, i_wr_tkeep);
        beat_idx++;
        if (exp_last) wait_sts = 1'b1;
      end

      if (i_sts_tvalid && i_sts_tlast && i_sts_tdata[3:0] == `WR_EOF_TAG) begin
        if (!wait_sts) report_fault("status arrived with no finished block");
        block_open = 1'b0;
        wait_sts   = 1'b0;
        o_blocks++;
      end
    end
  end

endmodule

//--- bench/capture_vectors.txt
// columns (hex): trigger gap in cycles, microsecond count, ready mode
// ready mode 0 keeps tready high, 1 takes it from the lcg
0010 002 0
0040 001 1
0008 003 1
0100 001 0
0020 004 1

//--- bench/tb_ad9434_capture.sv
`include "ad9434_cfg.svh"

module tb_ad9434_capture
  import adc_pkg::*;
  import s2mm_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic      adc_clk;
  logic      rst;
  logic      i_trig;
  us_count_t i_us_capture;
  half_t     i_adc_q1;
  half_t     i_adc_q2;
  logic      o_cap_done;
  logic      o_fifo_overflow;
  logic      cmd_tready;
  cmd_t      cmd_tdata;
  logic      cmd_tvalid;
  beat_t     wr_tdata;
  keep_t     wr_tkeep;
  logic      wr_tvalid;
  logic      wr_tlast;
  logic      wr_tready;
  sts_t      sts_tdata;
  logic      sts_tvalid;
  logic      sts_tlast;

  logic [15:0] vec [0:47];     // gap, us count, ready mode per test
  int          n_tests;
  longint      limit;          // timeout in cycles, 0 until known
  longint      run_cyc;
  int          tb_err;
  int          chk_err;
  int          blocks;
  int          samples;
  logic        ready_mode;     // 0 always ready, 1 lcg driven
  logic [31:0] lcg;
  int          sts_wait;       // cycles to the status beat

  ad9434_capture DUT (
    .adc_clk(adc_clk), .rst(rst), .i_trig(i_trig), .i_us_capture(i_us_capture),
    .i_adc_q1(i_adc_q1), .i_adc_q2(i_adc_q2), .o_cap_done(o_cap_done),
    .o_fifo_overflow(o_fifo_overflow), .i_s2mm_cmd_tready(cmd_tready),
    .o_s2mm_cmd_tdata(cmd_tdata), .o_s2mm_cmd_tvalid(cmd_tvalid),
    .o_s2mm_wr_tdata(wr_tdata), .o_s2mm_wr_tkeep(wr_tkeep), .o_s2mm_wr_tvalid(wr_tvalid),
    .o_s2mm_wr_tlast(wr_tlast), .i_s2mm_wr_tready(wr_tready),
    .i_s2mm_sts_tdata(sts_tdata), .i_s2mm_sts_tvalid(sts_tvalid),
    .i_s2mm_sts_tlast(sts_tlast)
  );

  bind ad9434_capture ad9434_capture_assert u_assert (.*);

  capture_checker u_checker (
    .i_clk(adc_clk), .i_rst(rst), .i_trig(i_trig), .i_us_capture(i_us_capture),
    .i_q1(i_adc_q1), .i_q2(i_adc_q2), .i_cap_done(o_cap_done),
    .i_cmd_tvalid(cmd_tvalid), .i_cmd_tready(cmd_tready), .i_cmd_tdata(cmd_tdata),
    .i_wr_tvalid(wr_tvalid), .i_wr_tready(wr_tready), .i_wr_tdata(wr_tdata),
    .i_wr_tkeep(wr_tkeep), .i_wr_tlast(wr_tlast), .i_sts_tvalid(sts_tvalid),
    .i_sts_tlast(sts_tlast), .i_sts_tdata(sts_tdata),
    .o_err_cnt(chk_err), .o_blocks(blocks), .o_samples(samples)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_cycle();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic finish_run();
    $display("errors: checker %0d, testbench %0d, assertions %0d; blocks %0d, samples %0d",
             chk_err, tb_err, DUT.u_assert.fail_cnt, blocks, samples);
    if (chk_err == 0 && tb_err == 0 && DUT.u_assert.fail_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  // adc data and datamover model, all driven 1 ns after the edge
  always @(posedge adc_clk) begin
    if (wr_tvalid && wr_tready && wr_tlast) sts_wait = 3;
    else if (sts_wait > 0) sts_wait--;
    #1;
    lcg        = lcg_next(lcg);
    i_adc_q1   = lcg[31:26];
    i_adc_q2   = lcg[25:20];
    cmd_tready = ready_mode ? lcg[13] : 1'b1;
    wr_tready  = ready_mode ? lcg[9] : 1'b1;
    sts_tvalid = (sts_wait == 1);  // status lands 3 edges after tlast
    sts_tlast  = (sts_wait == 1);
    sts_tdata  = {4'h0, `WR_EOF_TAG};
  end

  always @(posedge adc_clk) begin
    run_cyc++;
    if (limit > 0 && run_cyc > limit) begin
      $display("Error at %0t: timeout after %0d cycles, run did not complete", $time, run_cyc);
      tb_err++;
      finish_run();
    end
  end

  initial begin
    rst          = 1'b1;
    i_trig       = 1'b0;
    i_us_capture = '0;
    i_adc_q1     = '0;
    i_adc_q2     = '0;
    cmd_tready   = 1'b0;
    wr_tready    = 1'b0;
    sts_tdata    = '0;
    sts_tvalid   = 1'b0;
    sts_tlast    = 1'b0;
    lcg          = 32'h3ffa_b443;
    ready_mode   = 1'b0;
    sts_wait     = 0;
    tb_err       = 0;
    run_cyc      = 0;
    limit        = 0;
    n_tests      = 0;
    foreach (vec[i]) vec[i] = '1;  // all ones marks entries past the file end
    $readmemh("bench/capture_vectors.txt", vec);
    while (n_tests < 16 && vec[3*n_tests] != 16'hffff) n_tests++;
    limit = 2000 + 8;
    for (int t = 0; t < n_tests; t++)
      limit += vec[3*t] + vec[3*t+1] * `ADC_CYCLES_PER_US + 30;  // 30 for trigger handling
    repeat (8) next_cycle();
    rst = 1'b0;
    for (int t = 0; t < n_tests; t++) begin
      repeat (vec[3*t]) next_cycle();
      ready_mode   = vec[3*t+2][0];
      i_us_capture = us_count_t'(vec[3*t+1]);
      i_trig = 1'b1;
      repeat (2) next_cycle();
      i_trig = 1'b0;
      repeat (20) next_cycle();
      i_trig = 1'b1;                 // second edge lands inside the window
      repeat (2) next_cycle();
      i_trig = 1'b0;
      while (!o_cap_done) next_cycle();
    end
    while (blocks != samples / 128) next_cycle();  // 128 samples per block
    repeat (20) next_cycle();
    if (blocks != samples / 128) begin
      $display("Error at %0t: block count expected %0d got %0d", $time, samples / 128, blocks);
      tb_err++;
    end
    if (o_fifo_overflow) begin
      $display("Error at %0t: fifo overflow flag is set", $time);
      tb_err++;
    end
    finish_run();
  end

endmodule

//--- hdl/ad9434_capture.sv
module ad9434_capture
  import adc_pkg::*;
  import s2mm_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst,
  input  logic      i_trig,
  input  us_count_t i_us_capture,
  input  half_t     i_adc_q1,            // deserialized rising-edge half
  input  half_t     i_adc_q2,            // deserialized falling-edge half
  output logic      o_cap_done,
  output logic      o_fifo_overflow,
  input  logic      i_s2mm_cmd_tready,
  output cmd_t      o_s2mm_cmd_tdata,
  output logic      o_s2mm_cmd_tvalid,
  output beat_t     o_s2mm_wr_tdata,
  output keep_t     o_s2mm_wr_tkeep,
  output logic      o_s2mm_wr_tvalid,
  output logic      o_s2mm_wr_tlast,
  input  logic      i_s2mm_wr_tready,
  input  sts_t      i_s2mm_sts_tdata,
  input  logic      i_s2mm_sts_tvalid,
  input  logic      i_s2mm_sts_tlast
);

  logic  capture;       // window open
  beat_t beat;          // packed lanes
  logic  beat_valid;
  beat_t head;          // fifo output word
  logic  empty;
  logic  block_ready;
  logic  pop;

  capture_ctrl u_capture_ctrl (
    .i_clk        (adc_clk),
    .i_rst        (rst),
    .i_trig       (i_trig),
    .i_us_capture (i_us_capture),
    .o_capture    (capture),
    .o_cap_done   (o_cap_done)
  );

  sample_packer u_sample_packer (
    .i_clk        (adc_clk),
    .i_rst        (rst),
    .i_capture    (capture),
    .i_q1         (i_adc_q1),
    .i_q2         (i_adc_q2),
    .o_beat       (beat),
    .o_beat_valid (beat_valid)
  );

  beat_fifo u_beat_fifo (
    .i_clk           (adc_clk),
    .i_rst           (rst),
    .i_push          (beat_valid),
    .i_beat          (beat),
    .i_pop           (pop),
    .o_head          (head),
    .o_empty         (empty),
    .o_block_ready   (block_ready),
    .o_fifo_overflow (o_fifo_overflow)
  );

  s2mm_writer u_s2mm_writer (
    .i_clk         (adc_clk),
    .i_rst         (rst),
    .i_block_ready (block_ready),
    .i_head        (head),
    .i_empty       (empty),
    .o_pop         (pop),
    .i_cmd_tready  (i_s2mm_cmd_tready),
    .o_cmd_tdata   (o_s2mm_cmd_tdata),
    .o_cmd_tvalid  (o_s2mm_cmd_tvalid),
    .o_wr_tdata    (o_s2mm_wr_tdata),
    .o_wr_tkeep    (o_s2mm_wr_tkeep),
    .o_wr_tvalid   (o_s2mm_wr_tvalid),
    .o_wr_tlast    (o_s2mm_wr_tlast),
    .i_wr_tready   (i_s2mm_wr_tready),
    .i_sts_tdata   (i_s2mm_sts_tdata),
    .i_sts_tvalid  (i_s2mm_sts_tvalid),
    .i_sts_tlast   (i_s2mm_sts_tlast)
  );

endmodule

//--- hdl/ad9434_cfg.svh
`ifndef AD9434_CFG_SVH
`define AD9434_CFG_SVH

// adc_clk cycles in one microsecond of capture window
`define ADC_CYCLES_PER_US 200

// datamover block size in 64-bit beats
`define BLOCK_BEATS 32

// beat fifo entries, must be a power of two
`define FIFO_DEPTH 128

// tag carried in the command, echoed back in the status low nibble
`define WR_EOF_TAG 4'b1010

// destination address of every block
`define S2MM_BASE_ADDR 32'h0400_0000

// bytes per command, BLOCK_BEATS x 8 bytes
`define BLOCK_BYTES 256

`endif

//--- hdl/adc_pkg.sv
package adc_pkg;

  typedef logic [5:0] half_t;       // one ddr half, rising or falling edge
  typedef logic [11:0] sample_t;    // {rising half, falling half}
  typedef logic [15:0] lane_t;      // zero-extended sample, one beat lane
  typedef logic [9:0] us_count_t;   // capture length in microseconds

  // capture sequencing
  typedef enum logic [1:0] {
    cap_idle = 2'd0,                // waiting for a trigger edge
    cap_run  = 2'd1,                // window open, one sample per cycle
    cap_done = 2'd2                 // single done cycle
  } cap_state_t;

endpackage

//--- hdl/beat_fifo.sv
`include "ad9434_cfg.svh"

module beat_fifo
  import s2mm_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_push,
  input  beat_t i_beat,
  input  logic  i_pop,            // takes o_head this cycle
  output beat_t o_head,           // first word falls through
  output logic  o_empty,
  output logic  o_block_ready,    // at least one block buffered
  output logic  o_fifo_overflow   // sticky, a push hit a full fifo
);

  localparam int AW = $clog2(`FIFO_DEPTH);
  localparam int CW = AW + 1;
  localparam logic [CW-1:0] DEPTH_CNT = CW'(`FIFO_DEPTH);
  localparam logic [CW-1:0] BLOCK_CNT = CW'(`BLOCK_BEATS);

  beat_t         mem [`FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;           // pointers wrap on their own width
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;            // occupancy 0..FIFO_DEPTH
  logic          full;
  logic          wr_ok;
  logic          rd_ok;

  assign full  = (count == DEPTH_CNT);
  assign wr_ok = i_push && !full;  // beat is lost when full
  assign rd_ok = i_pop && !o_empty;

  always_ff @(posedge i_clk) begin
    if (wr_ok) mem[wr_ptr] <= i_beat;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      o_block_ready   <= 1'b0;
      o_fifo_overflow <= 1'b0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // none, or push and pop together
      endcase
      o_block_ready <= (count >= BLOCK_CNT);  // one cycle behind count
      if (i_push && full) o_fifo_overflow <= 1'b1;
    end
  end

  assign o_head  = mem[rd_ptr];
  assign o_empty = (count == '0);

endmodule

//--- hdl/capture_ctrl.sv
`include "ad9434_cfg.svh"

module capture_ctrl
  import adc_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_trig,          // async trigger
  input  us_count_t i_us_capture,    // window length, sampled at run start
  output logic      o_capture,       // high on every sample cycle
  output logic      o_cap_done       // one cycle after the window closes
);

  localparam int CYC_W = $clog2(`ADC_CYCLES_PER_US);
  localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(`ADC_CYCLES_PER_US - 1);

  logic             trig_s1;         // first sync stage
  logic             trig_s2;         // second sync stage
  logic             trig_s3;         // previous value, for edge detect
  logic             trig_rise;
  cap_state_t       state;
  cap_state_t       state_nxt;
  logic [CYC_W-1:0] cyc_cnt;         // cycles inside the current microsecond
  us_count_t        us_cnt;          // whole microseconds elapsed
  us_count_t        us_target;       // latched i_us_capture
  logic             run_end;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      trig_s1 <= 1'b0;
      trig_s2 <= 1'b0;
      trig_s3 <= 1'b0;
    end else begin
      trig_s1 <= i_trig;
      trig_s2 <= trig_s1;
      trig_s3 <= trig_s2;
    end
  end

  assign trig_rise = trig_s2 & ~trig_s3;  // adds no latency, edge seen with trig_s2

  // last cycle of the last microsecond
  assign run_end = (cyc_cnt == CYC_LAST) && (us_cnt + 1'b1 == us_target);

  always_comb begin
    state_nxt = state;
    case (state)
      cap_idle: if (trig_rise) state_nxt = (i_us_capture == '0) ? cap_done : cap_run;
      cap_run:  if (run_end) state_nxt = cap_done;
      cap_done: state_nxt = cap_idle;  // triggers here are dropped
      default:  state_nxt = cap_idle;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= cap_idle;
      cyc_cnt <= '0;
      us_cnt  <= '0;
    end else begin
      state <= state_nxt;
      if (state == cap_run) begin
        if (cyc_cnt == CYC_LAST) begin
          cyc_cnt <= '0;              // wrap, one more microsecond done
          us_cnt  <= us_cnt + 1'b1;
        end else begin
          cyc_cnt <= cyc_cnt + 1'b1;
        end
      end else begin
        cyc_cnt <= '0;
        us_cnt  <= '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == cap_idle && trig_rise) us_target <= i_us_capture;  // held for the whole run
  end

  assign o_capture  = (state == cap_run);
  assign o_cap_done = (state == cap_done);

endmodule

//--- hdl/s2mm_pkg.sv
package s2mm_pkg;

  typedef logic [63:0] beat_t;      // four 16-bit lanes
  typedef logic [7:0] keep_t;       // byte enables of a beat
  typedef logic [71:0] cmd_t;       // datamover write command
  typedef logic [7:0] sts_t;        // datamover status byte

  // block writer sequencing
  typedef enum logic [1:0] {
    wr_idle = 2'd0,                 // wait for a full block in the fifo
    wr_cmd  = 2'd1,                 // command offered to the datamover
    wr_data = 2'd2,                 // burst of BLOCK_BEATS beats
    wr_wait = 2'd3                  // wait for the tagged status
  } wr_state_t;

endpackage

//--- hdl/s2mm_writer.sv
`include "ad9434_cfg.svh"

module s2mm_writer
  import s2mm_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_block_ready,  // fifo holds a whole block
  input  beat_t i_head,
  input  logic  i_empty,
  output logic  o_pop,
  input  logic  i_cmd_tready,
  output cmd_t  o_cmd_tdata,
  output logic  o_cmd_tvalid,
  output beat_t o_wr_tdata,
  output keep_t o_wr_tkeep,
  output logic  o_wr_tvalid,
  output logic  o_wr_tlast,
  input  logic  i_wr_tready,
  input  sts_t  i_sts_tdata,
  input  logic  i_sts_tvalid,
  input  logic  i_sts_tlast
);

  localparam int CNT_W = $clog2(`BLOCK_BEATS);
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`BLOCK_BEATS - 1);

  // rsvd, tag, address, drr, eof/type byte, zero field, byte count
  localparam cmd_t WR_CMD = {
    4'd0,
    `WR_EOF_TAG,
    `S2MM_BASE_ADDR,
    1'b0,
    8'd1,
    14'd0,
    9'(`BLOCK_BYTES)
  };

  wr_state_t        state;
  wr_state_t        state_nxt;
  logic [CNT_W-1:0] beat_cnt;   // beats accepted in this block
  logic             beat_ok;    // beat accepted by the datamover
  logic             sts_ok;     // status that closes the block

  assign o_cmd_tdata  = WR_CMD;     // never changes, so stable while tvalid waits
  assign o_cmd_tvalid = (state == wr_cmd);

  assign o_wr_tdata  = i_head;
  assign o_wr_tkeep  = '1;          // whole beats only
  assign o_wr_tvalid = (state == wr_data) && !i_empty;
  assign o_wr_tlast  = (state == wr_data) && (beat_cnt == LAST_BEAT);

  assign beat_ok = o_wr_tvalid && i_wr_tready;
  assign o_pop   = beat_ok;         // fwft, head leaves on acceptance

  // tag must match, other status beats are dropped
  assign sts_ok = i_sts_tvalid && i_sts_tlast && (i_sts_tdata[3:0] == `WR_EOF_TAG);

  always_comb begin
    state_nxt = state;
    case (state)
      wr_idle: if (i_block_ready) state_nxt = wr_cmd;
      wr_cmd:  if (i_cmd_tready) state_nxt = wr_data;
      wr_data: if (beat_ok && o_wr_tlast) state_nxt = wr_wait;
      wr_wait: if (sts_ok) state_nxt = wr_idle;
      default: state_nxt = wr_idle;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= wr_idle;
      beat_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == wr_data) begin
        if (beat_ok) beat_cnt <= beat_cnt + 1'b1;  // wraps to 0 after tlast
      end else begin
        beat_cnt <= '0;
      end
    end
  end

endmodule

//--- hdl/sample_packer.sv
module sample_packer
  import adc_pkg::*;
  import s2mm_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_capture,     // sample this cycle
  input  half_t i_q1,          // rising-edge half
  input  half_t i_q2,          // falling-edge half
  output beat_t o_beat,        // four lanes, lane 0 in the low bits
  output logic  o_beat_valid   // strobe once the fourth lane is in
);

  localparam int LANE_W = $bits(lane_t);

  sample_t    sample;
  lane_t      lane;
  logic [1:0] lane_idx;        // next lane to fill, kept across captures

  assign sample = {i_q1, i_q2};    // rising half on top
  assign lane   = lane_t'(sample); // upper 4 bits zero

  // beat register is the packing buffer, lanes land straight from the pins
  always_ff @(posedge i_clk) begin
    if (i_capture) o_beat[LANE_W*lane_idx +: LANE_W] <= lane;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      lane_idx     <= 2'd0;
      o_beat_valid <= 1'b0;
    end else begin
      o_beat_valid <= i_capture && (lane_idx == 2'd3);  // lines up with lane 3 write
      if (i_capture) lane_idx <= lane_idx + 2'd1;      // wraps 3 -> 0
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_ad9434_capture -f ad9434_capture.f \
  && ./obj_dir/Vtb_ad9434_capture 2>&1)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1
